//--- include/dataPath_settings.svh
// datapath settings: word width, general register count and multiply length
`ifndef DATAPATH_SETTINGS_SVH
`define DATAPATH_SETTINGS_SVH

// width of one data word on the bus
`define DATA_WIDTH 32

// general purpose registers in the register file
`define REG_COUNT 16

// the shift-add multiplier retires one multiplier bit per cycle
`define MUL_STEPS `DATA_WIDTH

`endif

//--- rtl/alu.sv
// ALU with Z register: single-cycle operations and an unsigned shift-add multiplier
`include "dataPath_settings.svh"

module alu (
    input  logic                Clock,
    input  logic                rst,
    input  logic                start,
    input  dataPathPkg::aluOp_t aluOp,
    input  dataPathPkg::word_t  yValue,   // operand A
    input  dataPathPkg::word_t  busValue, // operand B
    output dataPathPkg::zWord_t zValue,
    output logic                finished
);

    import dataPathPkg::*;

    localparam int CountWidth = $clog2(`MUL_STEPS);
    localparam logic [CountWidth-1:0] LastStep = CountWidth'(`MUL_STEPS - 1);

    aluState_t state;
    zWord_t    zReg;
    word_t     singleResult;
    logic [4:0] shiftCount;
    logic [2*`DATA_WIDTH-1:0] rolWide;
    logic [2*`DATA_WIDTH-1:0] rorWide;

    // multiplier working registers
    zWord_t    mulCand;   // multiplicand, shifts left each step
    word_t     mulPlier;  // multiplier, shifts right each step
    zWord_t    partialSum;
    logic [CountWidth-1:0] stepCount;

    assign shiftCount = busValue[4:0]; // only the low five bits count

    // rotates shift a doubled copy and keep one half
    assign rolWide = {yValue, yValue} << shiftCount;
    assign rorWide = {yValue, yValue} >> shiftCount;

    always_comb begin
        case (aluOp)
            opAdd:   singleResult = yValue + busValue;
            opSub:   singleResult = yValue - busValue;
            opAnd:   singleResult = yValue & busValue;
            opOr:    singleResult = yValue | busValue;
            opShl:   singleResult = yValue << shiftCount;
            opShr:   singleResult = yValue >> shiftCount;
            opShra:  singleResult = word_t'($signed(yValue) >>> shiftCount);
            opRol:   singleResult = rolWide[2*`DATA_WIDTH-1:`DATA_WIDTH];
            opRor:   singleResult = rorWide[`DATA_WIDTH-1:0];
            opNeg:   singleResult = -busValue;
            opNot:   singleResult = ~busValue;
            default: singleResult = '0; // opMul goes through the sequencer
        endcase
    end

    // add the shifted multiplicand when the current multiplier bit is set
    assign partialSum = zReg + (mulPlier[0] ? mulCand : '0);

    always_ff @(posedge Clock) begin
        if (rst) begin
            state     <= aluIdle;
            zReg      <= '0;
            finished  <= 1'b0;
            stepCount <= '0;
        end else begin
            finished <= 1'b0;
            case (state)
                aluIdle: begin
                    if (start) begin
                        if (aluOp == opMul) begin
                            state     <= aluMul;
                            zReg      <= '0;  // accumulator starts empty
                            stepCount <= '0;
                        end else begin
                            zReg     <= zWord_t'(singleResult);
                            finished <= 1'b1;
                        end
                    end
                end
                aluMul: begin
                    zReg      <= partialSum;
                    stepCount <= stepCount + 1'b1;
                    if (stepCount == LastStep) begin
                        state    <= aluIdle;
                        finished <= 1'b1;
                    end
                end
            endcase
        end
    end

    // operands are captured at the start edge, bus and Y are free afterwards
    always_ff @(posedge Clock) begin
        if (state == aluIdle && start && aluOp == opMul) begin
            mulCand  <= zWord_t'(yValue);
            mulPlier <= busValue;
        end else if (state == aluMul) begin
            mulCand  <= mulCand << 1;
            mulPlier <= mulPlier >> 1;
        end
    end

    assign zValue = zReg;

    noStartWhileMul: assert property (
        @(posedge Clock) disable iff (rst)
        state == aluMul |-> !start
    ) else $error("start raised while the multiplier is busy");

    finishedOnePulse: assert property (
        @(posedge Clock) disable iff (rst)
        finished |=> !finished
    ) else $error("finished held for more than one cycle");

endmodule

//--- rtl/dataPath.sv
// single-bus datapath top: register file, special register bank and ALU on one shared bus
module dataPath (
    input  logic                  Clock,
    input  logic                  rst,
    input  dataPathPkg::ctrlWord_t ctrl,     // one control word per cycle
    input  dataPathPkg::word_t    mdataIn,  // memory read data
    output dataPathPkg::word_t    busValue,
    output dataPathPkg::word_t    marValue, // memory address
    output logic                  finished  // ALU done pulse
);

    import dataPathPkg::*;

    word_t  rfValue;
    word_t  yValue;
    zWord_t zValue;

    // general registers, written from the bus
    registerFile rf0 (
        .Clock    (Clock),
        .rst      (rst),
        .rfSelect (ctrl.rfSelect),
        .rfIn     (ctrl.rfIn),
        .busValue (busValue),
        .rfValue  (rfValue)
    );

    // special registers, also owns the bus multiplexer
    regBank rb0 (
        .Clock    (Clock),
        .rst      (rst),
        .ctrl     (ctrl),
        .mdataIn  (mdataIn),
        .rfValue  (rfValue),
        .zValue   (zValue),
        .busValue (busValue),
        .marValue (marValue),
        .yValue   (yValue)
    );

    // Y is operand A, the bus is operand B
    alu alu0 (
        .Clock    (Clock),
        .rst      (rst),
        .start    (ctrl.start),
        .aluOp    (ctrl.aluOp),
        .yValue   (yValue),
        .busValue (busValue),
        .zValue   (zValue),
        .finished (finished)
    );

endmodule

//--- rtl/dataPathPkg.sv
// datapath package: word, register index, ALU operation, bus source and control word types
`include "dataPath_settings.svh"

package dataPathPkg;

    typedef logic [`DATA_WIDTH-1:0]   word_t;   // one data word
    typedef logic [2*`DATA_WIDTH-1:0] zWord_t;  // Z register, high and low word
    typedef logic [3:0]               regIdx_t; // general register index

    // ALU operation codes, Y is operand A and the bus is operand B
    typedef enum logic [4:0] {
        opAdd  = 5'd0,
        opSub  = 5'd1,
        opAnd  = 5'd2,
        opOr   = 5'd3,
        opShl  = 5'd4,
        opShr  = 5'd5,
        opShra = 5'd6,  // arithmetic, keeps the sign bit
        opRol  = 5'd7,
        opRor  = 5'd8,
        opNeg  = 5'd9,  // two's complement of the bus
        opNot  = 5'd10, // bitwise inverse of the bus
        opMul  = 5'd11  // multi-cycle, unsigned
    } aluOp_t;

    // which register drives the shared bus
    typedef enum logic [3:0] {
        busNone = 4'd0, // bus reads as zero
        busRf   = 4'd1,
        busPc   = 4'd2,
        busIr   = 4'd3,
        busY    = 4'd4,
        busZlo  = 4'd5,
        busZhi  = 4'd6,
        busMar  = 4'd7,
        busHi   = 4'd8,
        busLo   = 4'd9,
        busMdr  = 4'd10
    } busSrc_t;

    // one control word per cycle from the external controller
    typedef struct packed {
        busSrc_t busSrc;
        regIdx_t rfSelect;
        logic    rfIn;
        logic    pcIn;
        logic    incPc;    // pcIn has priority
        logic    irIn;
        logic    yIn;
        logic    marIn;
        logic    hiIn;
        logic    loIn;
        logic    mdrIn;
        logic    read;     // MDR takes memory data instead of the bus
        logic    start;
        aluOp_t  aluOp;
    } ctrlWord_t;

    typedef enum logic {
        aluIdle,
        aluMul
    } aluState_t;

endpackage

//--- rtl/regBank.sv
// special register bank holding PC, IR, MAR, MDR, Y, HI and LO and driving the shared bus
`include "dataPath_settings.svh"

module regBank (
    input  logic                  Clock,
    input  logic                  rst,
    input  dataPathPkg::ctrlWord_t ctrl,
    input  dataPathPkg::word_t    mdataIn,  // data from external memory
    input  dataPathPkg::word_t    rfValue,  // selected general register
    input  dataPathPkg::zWord_t   zValue,   // ALU result register
    output dataPathPkg::word_t    busValue,
    output dataPathPkg::word_t    marValue, // memory address
    output dataPathPkg::word_t    yValue    // ALU operand A
);

    import dataPathPkg::*;

    word_t pc;
    word_t ir;
    word_t mar;
    word_t mdr;
    word_t y;
    word_t hi;
    word_t lo;

    // a load from the bus beats the increment
    always_ff @(posedge Clock) begin
        if (rst) begin
            pc <= '0;
        end else if (ctrl.pcIn) begin
            pc <= busValue;
        end else if (ctrl.incPc) begin
            pc <= pc + word_t'(1);
        end
    end

    // memory data register
    always_ff @(posedge Clock) begin
        if (rst) begin
            mdr <= '0;
        end else if (ctrl.mdrIn) begin
            mdr <= ctrl.read ? mdataIn : busValue;
        end
    end

    // remaining registers load straight from the bus
    always_ff @(posedge Clock) begin
        if (rst) begin
            ir  <= '0;
            mar <= '0;
            y   <= '0;
            hi  <= '0;
            lo  <= '0;
        end else begin
            if (ctrl.irIn) begin
                ir <= busValue;
            end
            if (ctrl.marIn) begin
                mar <= busValue;
            end
            if (ctrl.yIn) begin
                y <= busValue;
            end
            if (ctrl.hiIn) begin
                hi <= busValue;
            end
            if (ctrl.loIn) begin
                lo <= busValue;
            end
        end
    end

    // bus multiplexer picking one driver per cycle
    always_comb begin
        case (ctrl.busSrc)
            busNone: busValue = '0;
            busRf:   busValue = rfValue;
            busPc:   busValue = pc;
            busIr:   busValue = ir;
            busY:    busValue = y;
            busZlo:  busValue = zValue[`DATA_WIDTH-1:0];
            busZhi:  busValue = zValue[2*`DATA_WIDTH-1:`DATA_WIDTH];
            busMar:  busValue = mar;
            busHi:   busValue = hi;
            busLo:   busValue = lo;
            busMdr:  busValue = mdr;
            default: busValue = '0; // unused encodings
        endcase
    end

    assign marValue = mar;
    assign yValue   = y;

    // a memory read into MDR while MDR also drives the bus would mix old and new data
    mdrReadWhileDriving: assert property (
        @(posedge Clock) disable iff (rst)
        !(ctrl.mdrIn && ctrl.read && ctrl.busSrc == busMdr)
    ) else $error("MDR loaded from memory while driving the bus");

endmodule

//--- rtl/registerFile.sv
// general register file: sixteen words, one combinational read port and one write port
`include "dataPath_settings.svh"

module registerFile (
    input  logic                Clock,
    input  logic                rst,
    input  dataPathPkg::regIdx_t rfSelect, // read and write share the index
    input  logic                rfIn,
    input  dataPathPkg::word_t  busValue,
    output dataPathPkg::word_t  rfValue
);

    import dataPathPkg::*;

    word_t regs [`REG_COUNT];

    // write the bus into the selected entry
    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rfIn) begin
            regs[rfSelect] <= busValue;
        end
    end

    // read is combinational, a write shows up the cycle after
    assign rfValue = regs[rfSelect];

endmodule

//--- run.sh
#!/bin/sh
# build the datapath testbench with Verilator, run it and check the log
rm -f sim.log && \
    verilator --binary --timing --assert -Wno-fatal -f src.f \
        --top-module dataPathTb -o dataPathSim && \
    ./obj_dir/dataPathSim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- src.f
+incdir+include
rtl/dataPathPkg.sv
rtl/registerFile.sv
rtl/regBank.sv
rtl/alu.sv
rtl/dataPath.sv
tests/dataPathTb.sv

//--- tests/dataPathTb.sv
// datapath testbench driving control words and checking bus, Z, PC and MAR against an ALU model
`include "dataPath_settings.svh"

module dataPathTb;

    timeunit 1ns;
    timeprecision 100ps;

    import dataPathPkg::*;

    localparam int Msb = `DATA_WIDTH - 1;
    localparam int CycleLimit = 20000;  // enough for about 300 operations of up to 45 cycles
    localparam int FinishWait = 2 * `MUL_STEPS + 8;

    logic      Clock;
    logic      rst;
    ctrlWord_t ctrl;
    word_t     mdataIn;
    word_t     busValue;
    word_t     marValue;
    logic      finished;

    int seed;
    int errorCount;
    int checkCount;
    int cycleCount;
    int startCount;
    int pulseCount;

    // pending checks pushed by the stimulus and drained at the next rising edge
    string       nameQ [$];
    logic [63:0] expectQ [$];
    logic [63:0] actualQ [$];
    string       checkName;
    logic [63:0] expected;
    logic [63:0] actual;

    word_t   regModel [`REG_COUNT];  // expected general register contents
    busSrc_t specialSrc [10] = '{busNone, busPc, busIr, busY, busZlo,
                                 busZhi, busMar, busHi, busLo, busMdr};

    dataPath dut0 (
        .Clock    (Clock),
        .rst      (rst),
        .ctrl     (ctrl),
        .mdataIn  (mdataIn),
        .busValue (busValue),
        .marValue (marValue),
        .finished (finished)
    );

    always #5 Clock = ~Clock;

    // run limit
    always @(posedge Clock) begin
        cycleCount++;
        if (cycleCount >= CycleLimit) begin
            $display("timeout after %0d cycles, the test sequence did not complete", cycleCount);
            $display("%0d errors in %0d checks", errorCount, checkCount);
            $display("Errors found");
            $finish;
        end
    end

    // comparison of sampled values against the model
    always @(posedge Clock) begin
        while (nameQ.size() > 0) begin
            checkName = nameQ.pop_front();
            expected  = expectQ.pop_front();
            actual    = actualQ.pop_front();
            checkCount++;
            assert (actual === expected) else begin
                errorCount++;
                $display("error %s expected %h actual %h", checkName, expected, actual);
            end
        end
    end

    always @(negedge Clock) begin
        if (!rst && finished === 1'b1) begin
            pulseCount++;  // one count per high cycle
        end
    end

    // expected Z for one operation with Y as a and the bus as b
    function automatic logic [63:0] aluRef(input aluOp_t op, input word_t a, input word_t b);
        word_t r;
        int    count;
        int    i;
        count = int'(b[4:0]);
        r = a;
        case (op)
            opAdd: r = a + b;
            opSub: r = a - b;
            opAnd: r = a & b;
            opOr:  r = a | b;
            opShl: for (i = 0; i < count; i++) begin
                r = {r[Msb-1:0], 1'b0};
            end
            opShr: for (i = 0; i < count; i++) begin
                r = {1'b0, r[Msb:1]};
            end
            opShra: for (i = 0; i < count; i++) begin
                r = {r[Msb], r[Msb:1]};
            end
            opRol: for (i = 0; i < count; i++) begin
                r = {r[Msb-1:0], r[Msb]};
            end
            opRor: for (i = 0; i < count; i++) begin
                r = {r[0], r[Msb:1]};
            end
            opNeg: r = word_t'(0) - b;
            opNot: r = ~b;
            opMul: return 64'(a) * 64'(b);
            default: r = '0;
        endcase
        return 64'(r);  // single-cycle results are zero-extended
    endfunction

    task automatic drive(input ctrlWord_t c, input word_t mem);
        @(posedge Clock);
        #1;
        ctrl    = c;
        mdataIn = mem;
    endtask

    task automatic expectValue(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        nameQ.push_back(name);
        expectQ.push_back(exp);
        actualQ.push_back(act);
    endtask

    // memory data into MDR, then MDR to the register
    task automatic loadReg(input regIdx_t index, input word_t value);
        ctrlWord_t c;
        c = '0;
        c.mdrIn = 1'b1;
        c.read  = 1'b1;
        drive(c, value);
        c = '0;
        c.busSrc   = busMdr;
        c.rfSelect = index;
        c.rfIn     = 1'b1;
        drive(c, '0);
        regModel[index] = value;
    endtask

    task automatic readReg(input regIdx_t index, output word_t value);
        ctrlWord_t c;
        c = '0;
        c.busSrc   = busRf;
        c.rfSelect = index;
        drive(c, '0);
        @(negedge Clock);
        value = busValue;
    endtask

    task automatic compareRegisters();
        word_t readBack;
        for (int i = 0; i < `REG_COUNT; i++) begin
            readReg(regIdx_t'(i), readBack);
            expectValue($sformatf("busValue (R%0d)", i), 64'(regModel[i]), 64'(readBack));
        end
    endtask

    // Y from ra, start with rb on the bus, wait for finished, then read both Z words
    task automatic runOp(input aluOp_t op, input regIdx_t ra, input regIdx_t rb,
                         output logic [63:0] z, output int cycles);
        ctrlWord_t c;
        logic      done;
        word_t     zLo;
        word_t     zHi;
        c = '0;
        c.busSrc   = busRf;
        c.rfSelect = ra;
        c.yIn      = 1'b1;
        drive(c, '0);
        c = '0;
        c.busSrc   = busRf;
        c.rfSelect = rb;
        c.start    = 1'b1;
        c.aluOp    = op;
        drive(c, '0);
        startCount++;
        @(negedge Clock);
        expectValue("finished (start cycle)", 64'd0, 64'(finished));
        cycles = 0;
        done   = 1'b0;
        zLo    = '0;
        c = '0;
        c.busSrc = busZlo;
        while (!done && cycles < FinishWait) begin
            drive(c, '0);
            @(negedge Clock);
            cycles++;
            done = finished;
            zLo  = busValue;
        end
        assert (done) else begin
            errorCount++;
            $display("finished never rose within %0d cycles of start", FinishWait);
        end
        c.busSrc = busZhi;
        drive(c, '0);
        @(negedge Clock);
        zHi = busValue;
        expectValue("finished (after pulse)", 64'd0, 64'(finished));
        z = {zHi, zLo};
    endtask

    initial begin
        word_t       pcModel;
        logic [63:0] z;
        logic [4:0]  opCode;
        int          cycles;
        aluOp_t      op;
        ctrlWord_t   c;
        Clock      = 1'b0;
        rst        = 1'b1;
        ctrl       = '0;
        mdataIn    = '0;
        seed       = 32'hdb25_7225;
        errorCount = 0;
        checkCount = 0;
        cycleCount = 0;
        startCount = 0;
        pulseCount = 0;
        for (int i = 0; i < `REG_COUNT; i++) begin
            regModel[i] = '0;
        end
        repeat (16) @(posedge Clock);
        #1 rst = 1'b0;

        // every special register and the empty bus read zero after reset
        for (int i = 0; i < 10; i++) begin
            c = '0;
            c.busSrc = specialSrc[i];
            drive(c, '0);
            @(negedge Clock);
            expectValue($sformatf("busValue (%s)", specialSrc[i].name()),
                        64'd0, 64'(busValue));
            expectValue("finished", 64'd0, 64'(finished));
        end

        compareRegisters();
        for (int i = 0; i < `REG_COUNT; i++) begin
            loadReg(regIdx_t'(i), $random(seed));
        end
        compareRegisters();
        loadReg(4'd5, $random(seed));  // the other fifteen must keep their values
        compareRegisters();

        // known rotate case
        loadReg(4'd2, 32'hABC0_0012);
        loadReg(4'd3, 32'd8);
        runOp(opRol, 4'd2, 4'd3, z, cycles);
        expectValue("zValue (rol)", 64'h0000_0000_C000_12AB, z);

        for (int n = 0; n < 200; n++) begin
            opCode = 5'($unsigned($random(seed)) % 11);
            op     = aluOp_t'(opCode);
            loadReg(4'd4, $random(seed));
            loadReg(4'd5, $random(seed));
            runOp(op, 4'd4, 4'd5, z, cycles);
            expectValue($sformatf("zValue (%s)", op.name()),
                        aluRef(op, regModel[4], regModel[5]), z);
            expectValue("finished delay", 64'd1, 64'(cycles));
        end

        // multiplies start with the largest operands
        loadReg(4'd4, 32'hFFFF_FFFF);
        loadReg(4'd5, 32'hFFFF_FFFF);
        runOp(opMul, 4'd4, 4'd5, z, cycles);
        expectValue("zValue (mul)", aluRef(opMul, regModel[4], regModel[5]), z);
        for (int n = 0; n < 20; n++) begin
            loadReg(4'd8, $random(seed));
            loadReg(4'd9, $random(seed));
            runOp(opMul, 4'd8, 4'd9, z, cycles);
            expectValue("zValue (mul)", aluRef(opMul, regModel[8], regModel[9]), z);
        end

        // PC steps by one, then a bus load overrides the increment
        loadReg(4'd6, $random(seed));
        loadReg(4'd7, $random(seed));
        pcModel = '0;
        c = '0;
        c.busSrc = busPc;
        c.incPc  = 1'b1;
        for (int k = 0; k < 6; k++) begin
            drive(c, '0);
            @(negedge Clock);
            expectValue("busValue (PC)", 64'(pcModel), 64'(busValue));
            pcModel = pcModel + word_t'(1);
        end
        c = '0;
        c.busSrc   = busRf;
        c.rfSelect = 4'd6;
        c.pcIn     = 1'b1;
        c.incPc    = 1'b1;
        drive(c, '0);
        pcModel = regModel[6];
        c = '0;
        c.busSrc = busPc;
        drive(c, '0);
        @(negedge Clock);
        expectValue("busValue (PC load)", 64'(pcModel), 64'(busValue));

        // MAR shows up on the address port one cycle after its load
        c = '0;
        c.busSrc   = busRf;
        c.rfSelect = 4'd7;
        c.marIn    = 1'b1;
        drive(c, '0);
        @(negedge Clock);
        expectValue("marValue (before load)", 64'd0, 64'(marValue));
        c = '0;
        drive(c, '0);
        @(negedge Clock);
        expectValue("marValue", 64'(regModel[7]), 64'(marValue));

        repeat (2) @(posedge Clock);  // let the comparison process drain
        assert (pulseCount == startCount) else begin
            errorCount++;
            $display("finished was high in %0d cycles for %0d starts", pulseCount, startCount);
        end
        $display("%0d errors in %0d checks", errorCount, checkCount);
        if (errorCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule
